// ==== ncc_macros.svh ====
`ifndef NCC_MACROS_SVH
`define NCC_MACROS_SVH

// patch geometry, one descriptor row per strobe
`define NCC_PATCH_DIM 4

// signed input pixel
`define NCC_PIX_W 9

// log domain fields
`define NCC_EXP_W 5
`define NCC_FRAC_W 16

// antilog output, wide enough for an exponent sum of 17
`define NCC_MAG_W 18

// accumulator chain and patch score
`define NCC_ACC_W 32

// frame length in windows
`define NCC_FRAME_WINDOWS 16
`define NCC_WIN_IDX_W 4

`endif

// ==== nccMathPkg.sv ====
`include "ncc_macros.svh"

package nccMathPkg;

	// one signed pixel
	typedef logic signed [`NCC_PIX_W-1:0] pixel_t;

	// column 0 sits in the top bits
	typedef logic [`NCC_PATCH_DIM*`NCC_PIX_W-1:0] descRowData_t;

	// row-major, pixel (0,0) in the top bits
	typedef logic [`NCC_PATCH_DIM*`NCC_PATCH_DIM*`NCC_PIX_W-1:0] winPatch_t;

	// position of the leading one
	typedef logic [`NCC_EXP_W-1:0] exp_t;

	// bits below the leading one, left-aligned
	typedef logic [`NCC_FRAC_W-1:0] frac_t;

	// unsigned product magnitude
	typedef logic [`NCC_MAG_W-1:0] mag_t;

	// signed partial sums and scores
	typedef logic signed [`NCC_ACC_W-1:0] acc_t;

endpackage: nccMathPkg

// ==== nccCtrlPkg.sv ====
`include "ncc_macros.svh"

package nccCtrlPkg;

	// window handling states
	typedef enum logic {
		WIN_WAIT,
		WIN_LOAD
	} winState_t;

	// window position inside a frame
	typedef logic [`NCC_WIN_IDX_W-1:0] winIdx_t;

	// descriptor row pointer
	typedef logic [$clog2(`NCC_PATCH_DIM)-1:0] descRow_t;

endpackage: nccCtrlPkg

// ==== logConverter.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module logConverter
	import nccMathPkg::*;
	(
	input pixel_t pixel,
	output logic sign,
	output logic zero,
	output exp_t exp,
	output frac_t frac
	);

	logic [`NCC_PIX_W-1:0] magnitude;
	logic [`NCC_FRAC_W-1:0] norm;
	logic [3:0] leadZeros;

	assign sign = pixel[`NCC_PIX_W-1];
	// -256 still fits as unsigned 256
	assign magnitude = sign ? (~pixel + 1'b1) : pixel;
	assign zero = (magnitude == '0);

	// halving search, normalises so the leading one ends up in the top bit
	always_comb begin
		norm = {{(`NCC_FRAC_W-`NCC_PIX_W){1'b0}}, magnitude};
		leadZeros = '0;
		if (norm[`NCC_FRAC_W-1 -: 8] == '0) begin
			norm = norm << 8;
			leadZeros = leadZeros + 4'd8;
		end
		if (norm[`NCC_FRAC_W-1 -: 4] == '0) begin
			norm = norm << 4;
			leadZeros = leadZeros + 4'd4;
		end
		if (norm[`NCC_FRAC_W-1 -: 2] == '0) begin
			norm = norm << 2;
			leadZeros = leadZeros + 4'd2;
		end
		if (norm[`NCC_FRAC_W-1] == 1'b0) begin
			norm = norm << 1;
			leadZeros = leadZeros + 4'd1;
		end
	end

	always_comb begin
		if (zero) begin
			exp = '0;
			frac = '0;
		end else begin
			exp = exp_t'(`NCC_FRAC_W-1) - exp_t'(leadZeros);
			// drop the hidden one
			frac = {norm[`NCC_FRAC_W-2:0], 1'b0};
		end
	end

endmodule: logConverter

// ==== antilogUnit.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module antilogUnit
	import nccMathPkg::*;
	(
	input exp_t exp,
	input frac_t frac,
	output mag_t mag
	);

	// room for the hidden one, the fraction and the largest shift
	localparam int SHIFT_W = `NCC_FRAC_W + 1 + (1 << `NCC_EXP_W);

	logic [SHIFT_W-1:0] mantissa;
	logic [SHIFT_W-1:0] shifted;

	// 1.frac as a fixed point value with FRAC_W fraction bits
	assign mantissa = {{(SHIFT_W-`NCC_FRAC_W-1){1'b0}}, 1'b1, frac};

	assign shifted = mantissa << exp;

	// integer part only, fraction bits below the point are cut
	assign mag = shifted[`NCC_FRAC_W +: `NCC_MAG_W];

endmodule: antilogUnit

// ==== processingElement.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module processingElement
	import nccMathPkg::*;
	(
	input logic clk,
	input logic rst,
	input logic loadDesc,
	input logic loadWin,
	input logic descSignIn,
	input logic descZeroIn,
	input exp_t descExpIn,
	input frac_t descFracIn,
	input logic winSignIn,
	input logic winZeroIn,
	input exp_t winExpIn,
	input frac_t winFracIn,
	input acc_t accIn,
	output acc_t accOut
	);

	logic descSign, descZero, winSign, winZero;
	exp_t descExp, winExp;
	frac_t descFrac, winFrac;

	logic [`NCC_FRAC_W:0] fracSum;
	exp_t expSum;
	mag_t prodMag;
	acc_t product;

	// descriptor pixel, written once per descriptor row strobe
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descSign <= 1'b0;
			descZero <= 1'b0;
			descExp <= '0;
			descFrac <= '0;
		end else if (loadDesc) begin
			descSign <= descSignIn;
			descZero <= descZeroIn;
			descExp <= descExpIn;
			descFrac <= descFracIn;
		end
	end

	// window pixel
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winSign <= 1'b0;
			winZero <= 1'b0;
			winExp <= '0;
			winFrac <= '0;
		end else if (loadWin) begin
			winSign <= winSignIn;
			winZero <= winZeroIn;
			winExp <= winExpIn;
			winFrac <= winFracIn;
		end
	end

	// Mitchell product, a carry out of the fraction bumps the exponent
	assign fracSum = descFrac + winFrac;
	assign expSum = descExp + winExp + exp_t'(fracSum[`NCC_FRAC_W]);

	antilogUnit u_antilog (
		.exp(expSum),
		.frac(fracSum[`NCC_FRAC_W-1:0]),
		.mag(prodMag)
	);

	assign product = {{(`NCC_ACC_W-`NCC_MAG_W){1'b0}}, prodMag};

	always_comb begin
		if (descZero || winZero) begin
			accOut = accIn;
		end else if (descSign ^ winSign) begin
			accOut = accIn - product;
		end else begin
			accOut = accIn + product;
		end
	end

endmodule: processingElement

// ==== descLoader.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module descLoader
	import nccMathPkg::*;
	import nccCtrlPkg::*;
	(
	input logic clk,
	input logic rst,
	input logic descValid,
	input descRowData_t descData,
	output logic [`NCC_PATCH_DIM-1:0] rowLoad,
	output logic [`NCC_PATCH_DIM-1:0] descSign,
	output logic [`NCC_PATCH_DIM-1:0] descZero,
	output exp_t descExp [`NCC_PATCH_DIM],
	output frac_t descFrac [`NCC_PATCH_DIM]
	);

	descRow_t descRowNow;

	// row pointer, wraps after the last row
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descRowNow <= '0;
		end else if (descValid) begin
			descRowNow <= descRowNow + 1'b1;
		end
	end

	// one-hot row enable, only while a row is on the bus
	always_comb begin
		rowLoad = '0;
		if (descValid) begin
			rowLoad[descRowNow] = 1'b1;
		end
	end

	for (genvar c = 0; c < `NCC_PATCH_DIM; c++) begin: gCol
		logConverter u_log (
			.pixel(descData[(`NCC_PATCH_DIM-1-c)*`NCC_PIX_W +: `NCC_PIX_W]),
			.sign(descSign[c]),
			.zero(descZero[c]),
			.exp(descExp[c]),
			.frac(descFrac[c])
		);
	end

endmodule: descLoader

// ==== peArray.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module peArray
	import nccMathPkg::*;
	(
	input logic clk,
	input logic rst,
	input logic [`NCC_PATCH_DIM-1:0] rowLoad,
	input logic [`NCC_PATCH_DIM-1:0] descSign,
	input logic [`NCC_PATCH_DIM-1:0] descZero,
	input exp_t descExp [`NCC_PATCH_DIM],
	input frac_t descFrac [`NCC_PATCH_DIM],
	input logic winLoad,
	input winPatch_t winData,
	output acc_t patchScore
	);

	localparam int NPIX = `NCC_PATCH_DIM * `NCC_PATCH_DIM;

	// per row, element c reads accChain[r][c] and drives accChain[r][c+1]
	acc_t accChain [`NCC_PATCH_DIM][`NCC_PATCH_DIM+1];

	for (genvar r = 0; r < `NCC_PATCH_DIM; r++) begin: gRow
		assign accChain[r][0] = '0;

		for (genvar c = 0; c < `NCC_PATCH_DIM; c++) begin: gCol
			logic wSign;
			logic wZero;
			exp_t wExp;
			frac_t wFrac;

			logConverter u_winLog (
				.pixel(winData[(NPIX-1-(r*`NCC_PATCH_DIM+c))*`NCC_PIX_W +: `NCC_PIX_W]),
				.sign(wSign),
				.zero(wZero),
				.exp(wExp),
				.frac(wFrac)
			);

			processingElement u_pe (
				.clk(clk),
				.rst(rst),
				.loadDesc(rowLoad[r]),
				.loadWin(winLoad),
				.descSignIn(descSign[c]),
				.descZeroIn(descZero[c]),
				.descExpIn(descExp[c]),
				.descFracIn(descFrac[c]),
				.winSignIn(wSign),
				.winZeroIn(wZero),
				.winExpIn(wExp),
				.winFracIn(wFrac),
				.accIn(accChain[r][c]),
				.accOut(accChain[r][c+1])
			);
		end
	end

	// sum of the row totals at the chain ends
	always_comb begin
		patchScore = '0;
		for (int r = 0; r < `NCC_PATCH_DIM; r++) begin
			patchScore = patchScore + accChain[r][`NCC_PATCH_DIM];
		end
	end

endmodule: peArray

// ==== bestMatchTracker.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module bestMatchTracker
	import nccMathPkg::*;
	import nccCtrlPkg::*;
	(
	input logic clk,
	input logic rst,
	input logic winValid,
	input acc_t patchScore,
	output logic winLoad,
	output logic winDone,
	output logic frameDone,
	output acc_t winScore,
	output acc_t bestScore,
	output winIdx_t bestIndex
	);

	winState_t state, nextState;
	winIdx_t winCount;
	logic empty;
	logic takeNew;
	logic lastWindow;
	logic [`NCC_ACC_W-1:0] scoreMag;
	logic [`NCC_ACC_W-1:0] bestMag;

	always_comb begin
		nextState = state;
		winLoad = 1'b0;
		winDone = 1'b0;
		case (state)
			WIN_WAIT: begin
				if (winValid) begin
					winLoad = 1'b1;
					nextState = WIN_LOAD;
				end
			end
			WIN_LOAD: begin
				// score of the registered window is settled here
				winDone = 1'b1;
				nextState = WIN_WAIT;
			end
			default: nextState = WIN_WAIT;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= WIN_WAIT;
		end else begin
			state <= nextState;
		end
	end

	assign lastWindow = (winCount == winIdx_t'(`NCC_FRAME_WINDOWS - 1));
	assign frameDone = winDone && lastWindow;
	assign winScore = patchScore;

	// unsigned magnitudes, so the most negative score compares correctly
	assign scoreMag = patchScore[`NCC_ACC_W-1] ? (~patchScore + 1'b1) : patchScore;
	assign bestMag = bestScore[`NCC_ACC_W-1] ? (~bestScore + 1'b1) : bestScore;

	// strictly greater, so a tie keeps the earlier window
	assign takeNew = empty || (scoreMag > bestMag);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winCount <= '0;
			empty <= 1'b1;
			bestScore <= '0;
			bestIndex <= '0;
		end else if (winDone) begin
			if (takeNew) begin
				bestScore <= patchScore;
				bestIndex <= winCount;
			end
			// last window still lands in best, then the next frame starts empty
			if (lastWindow) begin
				winCount <= '0;
				empty <= 1'b1;
			end else begin
				winCount <= winCount + 1'b1;
				empty <= 1'b0;
			end
		end
	end

endmodule: bestMatchTracker

// ==== nccTop.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module nccTop
	import nccMathPkg::*;
	import nccCtrlPkg::*;
	(
	input logic clk,
	input logic rst,
	input logic descValid,
	input descRowData_t descData,
	input logic winValid,
	input winPatch_t winData,
	output logic winDone,
	output acc_t winScore,
	output logic frameDone,
	output acc_t bestScore,
	output winIdx_t bestIndex
	);

	logic [`NCC_PATCH_DIM-1:0] rowLoad;
	logic [`NCC_PATCH_DIM-1:0] descSign;
	logic [`NCC_PATCH_DIM-1:0] descZero;
	exp_t descExp [`NCC_PATCH_DIM];
	frac_t descFrac [`NCC_PATCH_DIM];
	logic winLoad;
	acc_t patchScore;

	descLoader u_descLoader (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descData(descData),
		.rowLoad(rowLoad),
		.descSign(descSign),
		.descZero(descZero),
		.descExp(descExp),
		.descFrac(descFrac)
	);

	peArray u_peArray (
		.clk(clk),
		.rst(rst),
		.rowLoad(rowLoad),
		.descSign(descSign),
		.descZero(descZero),
		.descExp(descExp),
		.descFrac(descFrac),
		.winLoad(winLoad),
		.winData(winData),
		.patchScore(patchScore)
	);

	bestMatchTracker u_tracker (
		.clk(clk),
		.rst(rst),
		.winValid(winValid),
		.patchScore(patchScore),
		.winLoad(winLoad),
		.winDone(winDone),
		.frameDone(frameDone),
		.winScore(winScore),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule: nccTop

// ==== tbNcc.sv ====
`timescale 1ns/10ps
`include "ncc_macros.svh"

module tbNcc
	import nccMathPkg::*;
	import nccCtrlPkg::*;
	;

	localparam int DIM = `NCC_PATCH_DIM;
	localparam int PW = `NCC_PIX_W;
	localparam int FW = `NCC_FRAC_W;
	localparam int NPIX = DIM * DIM;
	localparam int FRAME = `NCC_FRAME_WINDOWS;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_ENTRIES = 64;

	typedef enum bit {ENTRY_DESC, ENTRY_WIN} entryKind_t;

	logic clk;
	logic rst;
	logic descValid;
	descRowData_t descData;
	logic winValid;
	winPatch_t winData;
	logic winDone;
	acc_t winScore;
	logic frameDone;
	acc_t bestScore;
	winIdx_t bestIndex;

	// stimulus table built before reset is released
	entryKind_t tKind [MAX_ENTRIES];
	winPatch_t tData [MAX_ENTRIES];
	acc_t tScore [MAX_ENTRIES];
	bit tFrame [MAX_ENTRIES];
	int nEntries;

	// descriptor as the DUT will hold it at each point of the table
	pixel_t buildDesc [DIM][DIM];
	int buildRow;
	int buildWin;

	// expected tracker state
	acc_t expBest;
	winIdx_t expIdx;
	bit expEmpty;
	int winNum;

	int testCount;
	int errorCount;
	int cycleCount;
	int timeoutLimit;

	nccTop i_dut (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descData(descData),
		.winValid(winValid),
		.winData(winData),
		.winDone(winDone),
		.winScore(winScore),
		.frameDone(frameDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			$display("timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic checkScore(input string name, input acc_t got, input acc_t want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, want);
			errorCount++;
		end
	endtask

	task automatic checkIndex(input string name, input winIdx_t got, input winIdx_t want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%01h, expected 0x%01h", name, got, want);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string name, input bit got, input bit want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%01h, expected 0x%01h", name, got, want);
			errorCount++;
		end
	endtask

	// index of the highest set bit
	function automatic int leadPos(input int m);
		int p;
		p = 0;
		for (int b = 0; b < PW; b++) begin
			if (m[b]) begin
				p = b;
			end
		end
		return p;
	endfunction

	// Mitchell product where a fraction carry bumps the exponent
	function automatic acc_t pixProduct(input pixel_t a, input pixel_t b);
		int ma, mb, ea, eb, fa, fb, fs, es;
		longint mant;
		ma = int'(a);
		mb = int'(b);
		if (ma < 0) begin
			ma = -ma;
		end
		if (mb < 0) begin
			mb = -mb;
		end
		if (ma == 0 || mb == 0) begin
			return '0;
		end
		ea = leadPos(ma);
		eb = leadPos(mb);
		fa = (ma - (1 << ea)) << (FW - ea);
		fb = (mb - (1 << eb)) << (FW - eb);
		fs = fa + fb;
		es = ea + eb;
		if (fs >= (1 << FW)) begin
			fs = fs - (1 << FW);
			es = es + 1;
		end
		mant = ((longint'(1) << FW) + longint'(fs)) << es;
		mant = mant >> FW;
		return ((a < 0) != (b < 0)) ? acc_t'(-mant) : acc_t'(mant);
	endfunction

	function automatic acc_t modelScore(input winPatch_t w);
		acc_t sum;
		sum = '0;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				sum = sum + pixProduct(buildDesc[r][c],
					pixel_t'(w[(NPIX-1-(r*DIM+c))*PW +: PW]));
			end
		end
		return sum;
	endfunction

	function automatic longint absScore(input acc_t s);
		return (s < 0) ? -longint'(s) : longint'(s);
	endfunction

	// range stops at -255 to keep the negated descriptor representable
	function automatic descRowData_t randDescRow();
		descRowData_t row;
		for (int c = 0; c < DIM; c++) begin
			row[(DIM-1-c)*PW +: PW] = pixel_t'(int'($urandom % 511) - 255);
		end
		return row;
	endfunction

	function automatic winPatch_t randWindow();
		winPatch_t w;
		for (int i = 0; i < NPIX; i++) begin
			w[i*PW +: PW] = pixel_t'(int'($urandom % 512) - 256);
		end
		return w;
	endfunction

	// exact powers of two with random signs
	function automatic winPatch_t powWindow();
		winPatch_t w;
		int v;
		for (int i = 0; i < NPIX; i++) begin
			v = 1 << ($urandom % 8);
			if ($urandom % 2) begin
				v = -v;
			end
			w[i*PW +: PW] = pixel_t'(v);
		end
		return w;
	endfunction

	function automatic winPatch_t onesWindow();
		winPatch_t w;
		for (int i = 0; i < NPIX; i++) begin
			w[i*PW +: PW] = pixel_t'(1);
		end
		return w;
	endfunction

	function automatic winPatch_t descPatch(input int scale);
		winPatch_t w;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				w[(NPIX-1-(r*DIM+c))*PW +: PW] = pixel_t'(scale * int'(buildDesc[r][c]));
			end
		end
		return w;
	endfunction

	task automatic addDescRow(input descRowData_t row);
		tKind[nEntries] = ENTRY_DESC;
		tData[nEntries] = winPatch_t'(row);
		tScore[nEntries] = '0;
		tFrame[nEntries] = 1'b0;
		for (int c = 0; c < DIM; c++) begin
			buildDesc[buildRow][c] = pixel_t'(row[(DIM-1-c)*PW +: PW]);
		end
		buildRow = (buildRow + 1) % DIM;
		nEntries++;
	endtask

	task automatic addWindow(input winPatch_t w);
		tKind[nEntries] = ENTRY_WIN;
		tData[nEntries] = w;
		tScore[nEntries] = modelScore(w);
		tFrame[nEntries] = (buildWin == FRAME - 1);
		buildWin = (buildWin + 1) % FRAME;
		nEntries++;
	endtask

	task automatic buildTable();
		winPatch_t repeatWin;
		nEntries = 0;
		buildRow = 0;
		buildWin = 0;
		for (int r = 0; r < DIM; r++) begin
			addDescRow(randDescRow());
		end
		// first frame puts the negated descriptor ahead of the equal one
		addWindow('0);
		addWindow(powWindow());
		addWindow(descPatch(-1));
		addWindow(descPatch(1));
		for (int k = 0; k < 4; k++) begin
			addWindow(randWindow());
		end
		// same score as the current best keeps its index
		repeatWin = descPatch(-1);
		addWindow(repeatWin);
		addWindow(repeatWin);
		for (int k = 0; k < 6; k++) begin
			addWindow(randWindow());
		end
		// second frame starts with a weak window
		addWindow(onesWindow());
		addWindow(randWindow());
		for (int r = 0; r < DIM; r++) begin
			addDescRow(randDescRow());
		end
		addWindow(descPatch(1));
		for (int k = 0; k < 13; k++) begin
			addWindow(randWindow());
		end
	endtask

	task automatic checkIdle();
		int errsBefore;
		errsBefore = errorCount;
		checkScore("bestScore", bestScore, '0);
		checkIndex("bestIndex", bestIndex, '0);
		repeat (4) begin
			@(negedge clk);
			checkFlag("winDone", winDone, 1'b0);
			checkFlag("frameDone", frameDone, 1'b0);
		end
		testCount++;
		$display("test reset idle: %s", (errorCount == errsBefore) ? "ok" : "FAIL");
	endtask

	task automatic applyDescRow(input int i);
		@(negedge clk);
		descValid = 1'b1;
		descData = descRowData_t'(tData[i]);
		@(negedge clk);
		descValid = 1'b0;
		testCount++;
		$display("test %0d descriptor row: loaded", i);
	endtask

	task automatic applyWindow(input int i);
		int errsBefore;
		int thisWin;
		errsBefore = errorCount;
		thisWin = winNum;
		@(negedge clk);
		winValid = 1'b1;
		winData = tData[i];
		@(negedge clk);
		winValid = 1'b0;
		while (!winDone) begin
			@(negedge clk);
		end
		checkScore("winScore", winScore, tScore[i]);
		checkFlag("frameDone", frameDone, tFrame[i]);
		// strictly greater magnitude wins unless the tracker is empty
		if (expEmpty || absScore(tScore[i]) > absScore(expBest)) begin
			expBest = tScore[i];
			expIdx = winIdx_t'(winNum);
		end
		if (winNum == FRAME - 1) begin
			winNum = 0;
			expEmpty = 1'b1;
		end else begin
			winNum++;
			expEmpty = 1'b0;
		end
		@(negedge clk);
		checkFlag("winDone", winDone, 1'b0);
		checkScore("bestScore", bestScore, expBest);
		checkIndex("bestIndex", bestIndex, expIdx);
		testCount++;
		$display("test %0d window %0d score 0x%08h: %s", i, thisWin, tScore[i],
			(errorCount == errsBefore) ? "ok" : "FAIL");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		descValid = 1'b0;
		descData = '0;
		winValid = 1'b0;
		winData = '0;
		testCount = 0;
		errorCount = 0;
		cycleCount = 0;
		timeoutLimit = 0;
		expBest = '0;
		expIdx = '0;
		expEmpty = 1'b1;
		winNum = 0;
		void'($urandom(94));
		buildTable();
		timeoutLimit = (RESET_CYCLES + 4 * nEntries) * 2;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		checkIdle();
		for (int i = 0; i < nEntries; i++) begin
			if (tKind[i] == ENTRY_DESC) begin
				applyDescRow(i);
			end else begin
				applyWindow(i);
			end
		end
		@(negedge clk);
		$display("tests %0d, errors %0d", testCount, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule: tbNcc

// ==== verilog.f ====
+incdir+.
nccMathPkg.sv
nccCtrlPkg.sv
logConverter.sv
antilogUnit.sv
processingElement.sv
descLoader.sv
peArray.sv
bestMatchTracker.sv
nccTop.sv
tbNcc.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the template matcher testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbNcc -f verilog.f -o simNcc > build.log 2>&1 \
	&& ./obj_dir/simNcc > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^TB PASSED$" sim.log \
	&& echo "result: pass" \
	|| { echo "result: fail"; exit 1; }
